//--- include/video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Horizontal raster, in pixels
`define H_TOTAL      400
`define H_SYNC_START 360
`define H_SYNC_END   384
`define H_ACTIVE     352

// Vertical raster, in lines
`define V_TOTAL      262
`define V_SYNC_START 240
`define V_SYNC_END   243
`define V_ACTIVE     232

// 320x200 text window, end bounds exclusive
`define WIN_X0       16
`define WIN_X1       336
`define WIN_Y0       16
`define WIN_Y1       216
`define TEXT_COLS    40

// IO register indices
`define IO_VCTRL     0
`define IO_VSCRX_L   1
`define IO_VSCRX_H   2
`define IO_VSCRY     3
`define IO_VPALSEL   10
`define IO_VPALDATA  11
`define IO_VLINE     12
`define IO_VIRQLINE  13
`define IO_IRQMASK   14
`define IO_IRQSTAT   15

`endif

//--- rtl/video_pkg.sv
package video_pkg;

    // Raster position
    typedef logic [8:0]  hpos_t;       // Pixel within line
    typedef logic [8:0]  vpos_t;       // Line within frame

    // CPU side
    typedef logic [3:0]  io_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [10:0] tram_addr_t;  // Codes low half, attributes high half

    // Video fetch path
    typedef logic [9:0]  char_addr_t;  // One word per character cell
    typedef logic [10:0] chram_addr_t; // Code * 8 + glyph line

    // Colour
    typedef logic [5:0]  colidx_t;
    typedef logic [3:0]  rgb4_t;
    typedef logic [6:0]  palsel_t;     // Two bytes per palette entry

endpackage

//--- rtl/video_timing.sv
`timescale 1ns/10ps
`include "video_config.svh"

module video_timing import video_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    output hpos_t hpos,
    output vpos_t vpos,
    output logic  hsync,
    output logic  vsync,
    output logic  blank,
    output logic  vblank,
    output logic  line_next
);

    ////////////////////////////////////////
    // Counters
    ////////////////////////////////////////

    assign line_next = (hpos == hpos_t'(`H_TOTAL - 1)); // Last pixel of line

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hpos <= '0;
            vpos <= '0;
        end else if (line_next) begin
            hpos <= '0;
            if (vpos == vpos_t'(`V_TOTAL - 1))
                vpos <= '0;
            else
                vpos <= vpos + 1'b1;
        end else begin
            hpos <= hpos + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Sync and blank decode
    ////////////////////////////////////////

    assign hsync = (hpos >= hpos_t'(`H_SYNC_START)) && (hpos < hpos_t'(`H_SYNC_END));
    assign vsync = (vpos >= vpos_t'(`V_SYNC_START)) && (vpos < vpos_t'(`V_SYNC_END));

    assign vblank = (vpos >= vpos_t'(`V_ACTIVE));
    assign blank  = vblank || (hpos >= hpos_t'(`H_ACTIVE));

    // Counter must wrap before reaching the line length
    a_hpos_range: assert property (
        @(posedge clk) disable iff (reset)
        hpos < hpos_t'(`H_TOTAL)
    );

endmodule

//--- rtl/video_regs.sv
`timescale 1ns/10ps
`include "video_config.svh"

module video_regs import video_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  io_addr_t io_addr,
    input  byte_t    io_wrdata,
    input  logic     io_wren,
    output byte_t    io_rddata,
    input  vpos_t    vpos,
    input  logic     vblank,
    input  byte_t    pal_rddata,
    output logic     pal_wren,
    output palsel_t  vpalsel,
    output logic     text_enable,
    output logic     irq
);

    logic       text_priority;  // Stored only
    logic       sprites_enable; // Stored only
    logic [1:0] gfx_mode;       // Stored only
    logic [8:0] vscrx;
    byte_t      vscry;
    byte_t      virqline;
    logic       mask_line, mask_vblank;
    logic       stat_line, stat_vblank;
    logic       line_match, line_match_r, vblank_r;
    logic       line_event, vblank_event;
    logic       wr_stat;

    assign line_match   = (vpos == {1'b0, virqline});
    assign line_event   = line_match && !line_match_r;
    assign vblank_event = vblank && !vblank_r;

    assign pal_wren = io_wren && (io_addr == io_addr_t'(`IO_VPALDATA));
    assign wr_stat  = io_wren && (io_addr == io_addr_t'(`IO_IRQSTAT));

    assign irq = (stat_line && mask_line) || (stat_vblank && mask_vblank);

    ////////////////////////////////////////
    // Register writes and status
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {text_priority, sprites_enable, gfx_mode, text_enable} <= '0;
            vscrx        <= '0;
            vscry        <= '0;
            vpalsel      <= '0;
            virqline     <= '0;
            mask_line    <= 1'b0;
            mask_vblank  <= 1'b0;
            stat_line    <= 1'b0;
            stat_vblank  <= 1'b0;
            line_match_r <= 1'b1; // No event for the line current at reset
            vblank_r     <= 1'b0;
        end else begin
            line_match_r <= line_match;
            vblank_r     <= vblank;
            if (io_wren) begin
                case (io_addr)
                    io_addr_t'(`IO_VCTRL):
                        {text_priority, sprites_enable, gfx_mode, text_enable} <= io_wrdata[4:0];
                    io_addr_t'(`IO_VSCRX_L):  vscrx[7:0] <= io_wrdata;
                    io_addr_t'(`IO_VSCRX_H):  vscrx[8]   <= io_wrdata[0];
                    io_addr_t'(`IO_VSCRY):    vscry      <= io_wrdata;
                    io_addr_t'(`IO_VPALSEL):  vpalsel    <= io_wrdata[6:0];
                    io_addr_t'(`IO_VIRQLINE): virqline   <= io_wrdata;
                    io_addr_t'(`IO_IRQMASK):  {mask_line, mask_vblank} <= io_wrdata[1:0];
                    default: ;
                endcase
            end
            // A new event wins over a write-1 clear
            if (line_event)
                stat_line <= 1'b1;
            else if (wr_stat && io_wrdata[1])
                stat_line <= 1'b0;
            if (vblank_event)
                stat_vblank <= 1'b1;
            else if (wr_stat && io_wrdata[0])
                stat_vblank <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Readback
    ////////////////////////////////////////

    always_comb begin
        case (io_addr)
            io_addr_t'(`IO_VCTRL):
                io_rddata = {3'b0, text_priority, sprites_enable, gfx_mode, text_enable};
            io_addr_t'(`IO_VSCRX_L):  io_rddata = vscrx[7:0];
            io_addr_t'(`IO_VSCRX_H):  io_rddata = {7'b0, vscrx[8]};
            io_addr_t'(`IO_VSCRY):    io_rddata = vscry;
            io_addr_t'(`IO_VPALSEL):  io_rddata = {1'b0, vpalsel};
            io_addr_t'(`IO_VPALDATA): io_rddata = pal_rddata;
            io_addr_t'(`IO_VLINE):    io_rddata = vpos[7:0];
            io_addr_t'(`IO_VIRQLINE): io_rddata = virqline;
            io_addr_t'(`IO_IRQMASK):  io_rddata = {6'b0, mask_line, mask_vblank};
            io_addr_t'(`IO_IRQSTAT):  io_rddata = {6'b0, stat_line, stat_vblank};
            default:                  io_rddata = '0;
        endcase
    end

    // Status bits only rise from their raster events
    a_stat_line_src: assert property (
        @(posedge clk) disable iff (reset) $rose(stat_line) |-> $past(line_event));
    a_stat_vblank_src: assert property (
        @(posedge clk) disable iff (reset) $rose(stat_vblank) |-> $past(vblank_event));

endmodule

//--- rtl/text_ram.sv
`timescale 1ns/10ps

module text_ram import video_pkg::*; (
    input  logic        clk,
    input  tram_addr_t  cpu_addr,
    input  byte_t       cpu_wrdata,
    input  logic        cpu_wren,
    output byte_t       cpu_rddata,
    input  char_addr_t  vid_addr,
    output logic [15:0] vid_rddata
);

    byte_t      code_mem [1024];
    byte_t      attr_mem [1024];
    char_addr_t cpu_idx;
    logic       cpu_attr;

    assign cpu_idx  = cpu_addr[9:0];
    assign cpu_attr = cpu_addr[10]; // Upper 1 KiB holds attributes

    // CPU port
    always_ff @(posedge clk) begin
        if (cpu_wren && !cpu_attr)
            code_mem[cpu_idx] <= cpu_wrdata;
        if (cpu_wren && cpu_attr)
            attr_mem[cpu_idx] <= cpu_wrdata;
        cpu_rddata <= cpu_attr ? attr_mem[cpu_idx] : code_mem[cpu_idx];
    end

    // Video port, attribute in high byte
    always_ff @(posedge clk) begin
        vid_rddata <= {attr_mem[vid_addr], code_mem[vid_addr]};
    end

endmodule

//--- rtl/char_ram.sv
`timescale 1ns/10ps

module char_ram import video_pkg::*; (
    input  logic        clk,
    input  chram_addr_t cpu_addr,
    input  byte_t       cpu_wrdata,
    input  logic        cpu_wren,
    output byte_t       cpu_rddata,
    input  chram_addr_t vid_addr,
    output byte_t       vid_rddata
);

    byte_t glyph_mem [2048]; // 256 glyphs of 8 lines

    // CPU read/write port
    always_ff @(posedge clk) begin
        if (cpu_wren)
            glyph_mem[cpu_addr] <= cpu_wrdata;
        cpu_rddata <= glyph_mem[cpu_addr];
    end

    // Video read port
    always_ff @(posedge clk) begin
        vid_rddata <= glyph_mem[vid_addr];
    end

endmodule

//--- rtl/palette.sv
`timescale 1ns/10ps

module palette import video_pkg::*; (
    input  logic    clk,
    input  palsel_t addr,
    input  byte_t   wrdata,
    input  logic    wren,
    output byte_t   rddata,
    input  colidx_t colidx,
    output rgb4_t   pal_r,
    output rgb4_t   pal_g,
    output rgb4_t   pal_b
);

    byte_t   pal_mem [128];
    byte_t   gb_byte;
    byte_t   r_byte;

    ////////////////////////////////////////
    // CPU access
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wren)
            pal_mem[addr] <= wrdata;
        rddata <= pal_mem[addr];
    end

    ////////////////////////////////////////
    // Colour lookup
    ////////////////////////////////////////

    assign gb_byte = pal_mem[{colidx, 1'b0}]; // Green high nibble, blue low
    assign r_byte  = pal_mem[{colidx, 1'b1}]; // Red in low nibble

    assign pal_g = gb_byte[7:4];
    assign pal_b = gb_byte[3:0];
    assign pal_r = r_byte[3:0];

endmodule

//--- rtl/video.sv
`timescale 1ns/10ps
`include "video_config.svh"

module video import video_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // IO register window
    input  io_addr_t    io_addr,
    input  byte_t       io_wrdata,
    input  logic        io_wren,
    output byte_t       io_rddata,

    // Text RAM
    input  tram_addr_t  tram_addr,
    input  byte_t       tram_wrdata,
    input  logic        tram_wren,
    output byte_t       tram_rddata,

    // Glyph RAM
    input  chram_addr_t chram_addr,
    input  byte_t       chram_wrdata,
    input  logic        chram_wren,
    output byte_t       chram_rddata,

    // Video out
    output rgb4_t       vga_r,
    output rgb4_t       vga_g,
    output rgb4_t       vga_b,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output logic        vga_vblank,
    output logic        irq
);

    hpos_t       hpos, hpos_r, hpos_rr, hnext, hrel_rr;
    vpos_t       vpos, vrow;
    logic        hsync, vsync, blank, vblank, line_next;
    logic        hsync_r, hsync_rr, vsync_r, vsync_rr, blank_r, blank_rr;
    logic        text_enable, pal_wren;
    palsel_t     vpalsel;
    byte_t       pal_rddata;
    logic        vwin, in_window, win_r, win_rr, fetch_win, next_row;
    char_addr_t  row_base, char_addr;
    logic [15:0] text_word;
    chram_addr_t glyph_addr;
    byte_t       glyph_byte, attr_r;
    logic        glyph_bit;
    logic [3:0]  text_nibble;
    colidx_t     colidx;
    rgb4_t       pal_r, pal_g, pal_b;

    video_timing video_timing (
        .clk(clk), .reset(reset), .hpos(hpos), .vpos(vpos), .hsync(hsync),
        .vsync(vsync), .blank(blank), .vblank(vblank), .line_next(line_next));

    video_regs video_regs (
        .clk(clk), .reset(reset), .io_addr(io_addr), .io_wrdata(io_wrdata),
        .io_wren(io_wren), .io_rddata(io_rddata), .vpos(vpos), .vblank(vblank),
        .pal_rddata(pal_rddata), .pal_wren(pal_wren), .vpalsel(vpalsel),
        .text_enable(text_enable), .irq(irq));

    assign vga_vblank = vblank;

    ////////////////////////////////////////
    // Character address
    ////////////////////////////////////////

    assign vrow      = vpos - vpos_t'(`WIN_Y0);
    assign vwin      = (vpos >= vpos_t'(`WIN_Y0)) && (vpos < vpos_t'(`WIN_Y1));
    assign next_row  = line_next && vwin && (vrow[2:0] == 3'd7);
    assign hnext     = hpos - hpos_t'(`WIN_X0 - 1); // Window x of the next pixel
    assign fetch_win = vwin && (hpos >= hpos_t'(`WIN_X0 - 1)) && (hpos < hpos_t'(`WIN_X1 - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            row_base <= '0;
        else if (vblank)
            row_base <= '0;
        else if (next_row)
            row_base <= row_base + char_addr_t'(`TEXT_COLS);
    end

    // Load one pixel before each cell starts
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            char_addr <= '0;
        else if (hnext[2:0] == 3'd0)
            char_addr <= fetch_win ? row_base + char_addr_t'(hnext[8:3]) : '0;
    end

    text_ram text_ram (
        .clk(clk), .cpu_addr(tram_addr), .cpu_wrdata(tram_wrdata), .cpu_wren(tram_wren),
        .cpu_rddata(tram_rddata), .vid_addr(char_addr), .vid_rddata(text_word));

    assign glyph_addr = {text_word[7:0], vrow[2:0]};

    char_ram char_ram (
        .clk(clk), .cpu_addr(chram_addr), .cpu_wrdata(chram_wrdata), .cpu_wren(chram_wren),
        .cpu_rddata(chram_rddata), .vid_addr(glyph_addr), .vid_rddata(glyph_byte));

    ////////////////////////////////////////
    // Pipeline alignment
    ////////////////////////////////////////

    assign in_window = vwin && (hpos >= hpos_t'(`WIN_X0)) && (hpos < hpos_t'(`WIN_X1));

    always_ff @(posedge clk) begin
        hpos_r  <= hpos;
        hpos_rr <= hpos_r;
        win_r   <= in_window;
        win_rr  <= win_r;
        attr_r  <= text_word[15:8]; // Hold attribute alongside glyph
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {hsync_r, hsync_rr, vsync_r, vsync_rr} <= '0;
            blank_r  <= 1'b1;
            blank_rr <= 1'b1;
        end else begin
            hsync_r  <= hsync;
            hsync_rr <= hsync_r;
            vsync_r  <= vsync;
            vsync_rr <= vsync_r;
            blank_r  <= blank;
            blank_rr <= blank_r;
        end
    end

    // Leftmost pixel is bit 7
    assign hrel_rr     = hpos_rr - hpos_t'(`WIN_X0);
    assign glyph_bit   = glyph_byte[~hrel_rr[2:0]];
    assign text_nibble = glyph_bit ? attr_r[7:4] : attr_r[3:0];
    assign colidx      = (text_enable && win_rr) ? colidx_t'(text_nibble) : '0;

    palette palette (
        .clk(clk), .addr(vpalsel), .wrdata(io_wrdata), .wren(pal_wren),
        .rddata(pal_rddata), .colidx(colidx), .pal_r(pal_r), .pal_g(pal_g), .pal_b(pal_b));

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {vga_r, vga_g, vga_b} <= '0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
        end else begin
            vga_r     <= blank_rr ? 4'h0 : pal_r;
            vga_g     <= blank_rr ? 4'h0 : pal_g;
            vga_b     <= blank_rr ? 4'h0 : pal_b;
            vga_hsync <= hsync_rr;
            vga_vsync <= vsync_rr;
        end
    end

endmodule

//--- dv/video_tb.sv
`timescale 1ns/10ps
`include "video_config.svh"

module video_tb import video_pkg::*; ();

    localparam int FRAME_CYCLES    = `H_TOTAL * `V_TOTAL;
    localparam int FILL_CYCLES     = 2048 + 8 + 32;
    localparam int STEP_BUDGET     = 512;
    localparam int WATCHDOG_CYCLES = 8 * FRAME_CYCLES + FILL_CYCLES + STEP_BUDGET;

    localparam logic [2:0] OP_IO_WR    = 3'd0;
    localparam logic [2:0] OP_IO_RD    = 3'd1;
    localparam logic [2:0] OP_TRAM_WR  = 3'd2;
    localparam logic [2:0] OP_TRAM_RD  = 3'd3;
    localparam logic [2:0] OP_CHRAM_WR = 3'd4;
    localparam logic [2:0] OP_CHRAM_RD = 3'd5;

    localparam int SIG_VSYNC  = 0;
    localparam int SIG_VBLANK = 1;
    localparam int SIG_IRQ    = 2;

    // Colours as {r, g, b}
    localparam logic [11:0] BORDER_RGB = 12'h469; // Entry 0
    localparam logic [11:0] BG_RGB     = 12'h1e7; // Entry 2
    localparam logic [11:0] FG_RGB     = 12'ha3c; // Entry 5

    typedef struct packed {
        logic [2:0]  op;
        logic [10:0] addr;
        byte_t       data;
        byte_t       want;
    } step_t;

    logic        clk = 1'b0;
    logic        reset;
    io_addr_t    io_addr;
    byte_t       io_wrdata, io_rddata;
    logic        io_wren;
    tram_addr_t  tram_addr;
    byte_t       tram_wrdata, tram_rddata;
    logic        tram_wren;
    chram_addr_t chram_addr;
    byte_t       chram_wrdata, chram_rddata;
    logic        chram_wren;
    rgb4_t       vga_r, vga_g, vga_b;
    logic        vga_hsync, vga_vsync, vga_vblank, irq;

    step_t       steps[$];
    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng_state = 32'h2cc5;

    video uut (
        .clk(clk), .reset(reset),
        .io_addr(io_addr), .io_wrdata(io_wrdata), .io_wren(io_wren), .io_rddata(io_rddata),
        .tram_addr(tram_addr), .tram_wrdata(tram_wrdata), .tram_wren(tram_wren),
        .tram_rddata(tram_rddata),
        .chram_addr(chram_addr), .chram_wrdata(chram_wrdata), .chram_wren(chram_wren),
        .chram_rddata(chram_rddata),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync), .vga_vblank(vga_vblank), .irq(irq));

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Reference pixel from the window and glyph rules
    function automatic logic [11:0] expected_rgb(input int h, input int v, input logic text_on);
        if (h >= `H_ACTIVE || v >= `V_ACTIVE)
            return 12'h000;
        if (text_on && h >= `WIN_X0 && h < `WIN_X1 && v >= `WIN_Y0 && v < `WIN_Y1)
            return (((h - `WIN_X0) % 8) < 4) ? FG_RGB : BG_RGB; // Glyph 0xF0
        return BORDER_RGB;
    endfunction

    // vblank is undelayed, so it runs three pixels ahead of the colour outputs
    function automatic logic expected_vblank(input int h, input int v);
        int cv;
        cv = v;
        if (h + 3 >= `H_TOTAL)
            cv = (v == `V_TOTAL - 1) ? 0 : v + 1;
        return cv >= `V_ACTIVE;
    endfunction

    function automatic logic watched(input int which);
        case (which)
            SIG_VSYNC:  return vga_vsync;
            SIG_VBLANK: return vga_vblank;
            default:    return irq;
        endcase
    endfunction

    // Returns on the falling edge where the signal is first seen high
    task automatic wait_for_rise(input int which, input string what);
        logic prev;
        int   n;
        prev = watched(which);
        for (n = 0; n <= FRAME_CYCLES + 100; n++) begin
            @(negedge clk);
            if (watched(which) && !prev)
                return;
            prev = watched(which);
        end
        errors++;
        $display("Timed out waiting for %s to rise at %0t", what, $time);
    endtask

    ////////////////////////////////////////
    // Bus access, one clock each
    ////////////////////////////////////////

    task automatic io_write(input io_addr_t a, input byte_t d);
        io_addr   = a;
        io_wrdata = d;
        io_wren   = 1'b1;
        @(negedge clk);
        io_wren   = 1'b0;
    endtask

    task automatic io_read(input io_addr_t a, output byte_t d);
        io_addr = a;
        @(negedge clk);
        d = io_rddata;
    endtask

    task automatic io_read_check(input io_addr_t a, input byte_t exp);
        byte_t d;
        io_read(a, d);
        check_value(32'(d), 32'(exp), $sformatf("io register %0d", a));
    endtask

    task automatic tram_write(input tram_addr_t a, input byte_t d);
        tram_addr   = a;
        tram_wrdata = d;
        tram_wren   = 1'b1;
        @(negedge clk);
        tram_wren   = 1'b0;
    endtask

    task automatic tram_read_check(input tram_addr_t a, input byte_t exp);
        tram_addr = a;
        @(negedge clk); // Data of the previous edge's address
        check_value(32'(tram_rddata), 32'(exp), $sformatf("text RAM byte %0h", a));
    endtask

    task automatic chram_write(input chram_addr_t a, input byte_t d);
        chram_addr   = a;
        chram_wrdata = d;
        chram_wren   = 1'b1;
        @(negedge clk);
        chram_wren   = 1'b0;
    endtask

    task automatic chram_read_check(input chram_addr_t a, input byte_t exp);
        chram_addr = a;
        @(negedge clk);
        check_value(32'(chram_rddata), 32'(exp), $sformatf("glyph RAM byte %0h", a));
    endtask

    task automatic set_palette_entry(input int idx, input logic [11:0] rgb);
        io_write(io_addr_t'(`IO_VPALSEL), 8'(2 * idx));
        io_write(io_addr_t'(`IO_VPALDATA), rgb[7:0]);          // Green and blue
        io_write(io_addr_t'(`IO_VPALSEL), 8'(2 * idx + 1));
        io_write(io_addr_t'(`IO_VPALDATA), {4'h0, rgb[11:8]}); // Red
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    task automatic add_step(input logic [2:0] op, input logic [10:0] addr,
                            input byte_t data, input byte_t want);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.want = want;
        steps.push_back(s);
    endtask

    task automatic add_reg_check(input int idx, input byte_t wr, input byte_t rd);
        add_step(OP_IO_WR, 11'(idx), wr, 8'h00);
        add_step(OP_IO_RD, 11'(idx), 8'h00, rd);
    endtask

    task automatic build_table();
        byte_t       d;
        logic [10:0] a;
        int          i;
        for (i = 0; i < 16; i++)
            if (i != `IO_VPALDATA) // Palette data comes from RAM
                add_step(OP_IO_RD, 11'(i), 8'h00, 8'h00); // Reset values
        add_reg_check(`IO_VCTRL, 8'hff, 8'h1f);
        add_reg_check(`IO_VSCRX_L, 8'ha5, 8'ha5);
        add_reg_check(`IO_VSCRX_H, 8'hff, 8'h01);
        add_reg_check(`IO_VSCRY, 8'h3c, 8'h3c);
        add_reg_check(`IO_VPALSEL, 8'hff, 8'h7f);
        add_reg_check(`IO_VIRQLINE, 8'h77, 8'h77);
        add_reg_check(`IO_IRQMASK, 8'hff, 8'h03);
        for (i = 4; i < 10; i++)
            add_reg_check(i, 8'hff, 8'h00);           // Unmapped
        add_reg_check(`IO_VCTRL, 8'h00, 8'h00);
        add_reg_check(`IO_IRQMASK, 8'h00, 8'h00);
        for (i = 0; i < 24; i++) begin
            rng_state = next_random(rng_state);
            a = rng_state[18:8];
            d = rng_state[7:0];
            add_step(OP_TRAM_WR, a, d, 8'h00);
            add_step(OP_TRAM_RD, a, 8'h00, d);
            rng_state = next_random(rng_state);
            a = rng_state[18:8];
            d = rng_state[7:0];
            add_step(OP_CHRAM_WR, a, d, 8'h00);
            add_step(OP_CHRAM_RD, a, 8'h00, d);
        end
        for (i = 0; i < 4; i++) begin
            rng_state = next_random(rng_state);
            add_step(OP_IO_WR, 11'(`IO_VPALSEL), {1'b0, rng_state[14:8]}, 8'h00);
            add_step(OP_IO_WR, 11'(`IO_VPALDATA), rng_state[7:0], 8'h00);
            add_step(OP_IO_RD, 11'(`IO_VPALDATA), 8'h00, rng_state[7:0]);
        end
    endtask

    task automatic run_step(input step_t s);
        case (s.op)
            OP_IO_WR:    io_write(io_addr_t'(s.addr), s.data);
            OP_IO_RD:    io_read_check(io_addr_t'(s.addr), s.want);
            OP_TRAM_WR:  tram_write(s.addr, s.data);
            OP_TRAM_RD:  tram_read_check(s.addr, s.want);
            OP_CHRAM_WR: chram_write(s.addr, s.data);
            default:     chram_read_check(s.addr, s.want);
        endcase
    endtask

    ////////////////////////////////////////
    // Raster checks
    ////////////////////////////////////////

    // Checks one full frame, starting at the next vsync
    task automatic check_frame(input logic text_on);
        int   h, v, n;
        logic hs_prev;
        wait_for_rise(SIG_VSYNC, "vsync");
        h = 0;
        v = `V_SYNC_START; // Output pixel at vsync rise
        hs_prev = vga_hsync;
        for (n = 0; n < FRAME_CYCLES; n++) begin
            @(negedge clk);
            h++;
            if (h == `H_TOTAL) begin
                h = 0;
                v = (v == `V_TOTAL - 1) ? 0 : v + 1;
            end
            if (vga_hsync && !hs_prev) begin
                if (h != `H_SYNC_START) begin
                    errors++;
                    $display("hsync rose at pixel %0d of line %0d, not at the sync start", h, v);
                end
                h = `H_SYNC_START;
            end
            hs_prev = vga_hsync;
            check_value(32'({vga_r, vga_g, vga_b}), 32'(expected_rgb(h, v, text_on)),
                        $sformatf("pixel (%0d,%0d)", h, v));
            check_value(32'(vga_vblank), 32'(expected_vblank(h, v)),
                        $sformatf("vblank at (%0d,%0d)", h, v));
        end
        check_value(32'(vga_vsync), 32'd1, "vsync after one frame");
    endtask

    task automatic load_text_screen();
        int i;
        for (i = 0; i < 1024; i++)
            tram_write(tram_addr_t'(i), 8'h01);
        for (i = 0; i < 1024; i++)
            tram_write(tram_addr_t'(1024 + i), 8'h52); // Fg 5, bg 2
        for (i = 0; i < 8; i++)
            chram_write({8'h01, 3'(i)}, 8'hf0);
        set_palette_entry(5, FG_RGB);
        set_palette_entry(2, BG_RGB);
        set_palette_entry(0, BORDER_RGB);
    endtask

    task automatic check_line_irq();
        byte_t d;
        io_write(io_addr_t'(`IO_VIRQLINE), 8'd100);
        io_write(io_addr_t'(`IO_IRQSTAT), 8'h03);
        io_write(io_addr_t'(`IO_IRQMASK), 8'h02);
        check_value(32'(irq), 32'd0, "irq before line match");
        wait_for_rise(SIG_IRQ, "line irq");
        io_read(io_addr_t'(`IO_VLINE), d);
        check_value(32'(d), 32'd100, "vline at line irq");
        io_read(io_addr_t'(`IO_IRQSTAT), d);
        check_value(32'(d[1]), 32'd1, "irqstat line bit");
        io_write(io_addr_t'(`IO_IRQSTAT), 8'h02); // Write 1 to clear
        check_value(32'(irq), 32'd0, "irq after line clear");
        io_write(io_addr_t'(`IO_IRQMASK), 8'h00);
    endtask

    task automatic check_vblank_irq();
        byte_t d;
        io_write(io_addr_t'(`IO_IRQMASK), 8'h01);
        io_write(io_addr_t'(`IO_IRQSTAT), 8'h03);
        check_value(32'(irq), 32'd0, "irq before vblank");
        wait_for_rise(SIG_VBLANK, "vblank");
        io_read(io_addr_t'(`IO_IRQSTAT), d);
        check_value(32'(d[0]), 32'd1, "irqstat vblank bit, masked on");
        check_value(32'(irq), 32'd1, "irq on vblank");
        io_write(io_addr_t'(`IO_IRQSTAT), 8'h01);
        check_value(32'(irq), 32'd0, "irq after vblank clear");

        // Status still sets with the mask off
        io_write(io_addr_t'(`IO_IRQMASK), 8'h00);
        wait_for_rise(SIG_VBLANK, "vblank");
        io_read(io_addr_t'(`IO_IRQSTAT), d);
        check_value(32'(d[0]), 32'd1, "irqstat vblank bit, masked off");
        check_value(32'(irq), 32'd0, "irq with vblank masked");
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        reset        = 1'b1;
        io_addr      = '0;
        io_wrdata    = '0;
        io_wren      = 1'b0;
        tram_addr    = '0;
        tram_wrdata  = '0;
        tram_wren    = 1'b0;
        chram_addr   = '0;
        chram_wrdata = '0;
        chram_wren   = 1'b0;
        build_table();
        repeat (8) @(negedge clk);
        reset = 1'b0;

        check_value(32'(irq), 32'd0, "irq after reset");
        foreach (steps[i])
            run_step(steps[i]);

        load_text_screen();
        io_write(io_addr_t'(`IO_VCTRL), 8'h01); // Text on
        check_frame(1'b1);
        io_write(io_addr_t'(`IO_VCTRL), 8'h00);
        check_frame(1'b0);

        check_line_irq();
        check_vblank_irq();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // Covers the table, RAM fill and the frames the raster tests wait on
    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
rtl/video_pkg.sv
rtl/video_timing.sv
rtl/video_regs.sv
rtl/text_ram.sv
rtl/char_ram.sv
rtl/palette.sv
rtl/video.sv
dv/video_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = video_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST)) include/video_config.svh
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@grep -q "TESTBENCH PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
